// File: Makefile
# Verilator build and run for the I/O SoC testbench

VERILATOR ?= verilator
TOP       ?= tb_io_soc
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: flist.f
+incdir+test
rtl/io_soc_pkg.sv
rtl/io_req_fifo.sv
rtl/io_decoder.sv
rtl/sys_ctrl.sv
rtl/gpio_port.sv
rtl/io_soc_top.sv
test/tb_io_soc.sv

// File: rtl/gpio_port.sv
module gpio_port (
   input  logic                          i_clk,
   input  logic                          i_reset,
   input  io_soc_pkg::periph_req_t       i_req,
   input  logic [io_soc_pkg::GPIO_W-1:0] i_gpio,
   output logic [io_soc_pkg::DATA_W-1:0] o_rdata,
   output logic [io_soc_pkg::GPIO_W-1:0] o_gpio,
   output logic [io_soc_pkg::GPIO_W-1:0] o_gpio_oe,
   output logic                          o_irq
);

   import io_soc_pkg::*;

   logic [GPIO_W-1:0] out_q;
   logic [GPIO_W-1:0] oe_q;
   logic [GPIO_W-1:0] ie_q;
   logic [GPIO_W-1:0] edge_q;
   logic [GPIO_W-1:0] sync_q1;
   logic [GPIO_W-1:0] sync_q2;
   logic [GPIO_W-1:0] in_last;
   logic [GPIO_W-1:0] rise;
   logic [GPIO_W-1:0] clr;
   logic [GPIO_W-1:0] wmask;
   logic [GPIO_W-1:0] wdata;
   logic              wr;

   assign wr    = i_req.sel && i_req.write;
   assign wmask = GPIO_W'(strb_mask(i_req.strb));
   assign wdata = i_req.wdata[GPIO_W-1:0];

   // Only undriven pins can capture an edge
   assign rise = sync_q2 & ~in_last & ~oe_q;
   assign clr  = (wr && (i_req.reg_idx == GPIO_EDGE)) ? (wdata & wmask) : '0;

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         out_q   <= '0;
         oe_q    <= '0;
         ie_q    <= '0;
         edge_q  <= '0;
         sync_q1 <= '0;
         sync_q2 <= '0;
         in_last <= '0;
      end else begin
         sync_q1 <= i_gpio;
         sync_q2 <= sync_q1;
         in_last <= sync_q2;
         // capture beats clear
         edge_q  <= (edge_q & ~clr) | rise;
         if (wr && (i_req.reg_idx == GPIO_OUT)) begin
            out_q <= (out_q & ~wmask) | (wdata & wmask);
         end
         if (wr && (i_req.reg_idx == GPIO_OE)) begin
            oe_q <= (oe_q & ~wmask) | (wdata & wmask);
         end
         if (wr && (i_req.reg_idx == GPIO_IE)) begin
            ie_q <= (ie_q & ~wmask) | (wdata & wmask);
         end
      end
   end

   assign o_gpio    = out_q;
   assign o_gpio_oe = oe_q;
   assign o_irq     = |(edge_q & ie_q);

   always_comb begin
      case (i_req.reg_idx)
         GPIO_OUT:  o_rdata = DATA_W'(out_q);
         GPIO_OE:   o_rdata = DATA_W'(oe_q);
         GPIO_IN:   o_rdata = DATA_W'(sync_q2);
         GPIO_EDGE: o_rdata = DATA_W'(edge_q);
         GPIO_IE:   o_rdata = DATA_W'(ie_q);
         default:   o_rdata = '0;
      endcase
   end

endmodule

// File: rtl/io_decoder.sv
module io_decoder (
   input  logic                             i_clk,
   input  logic                             i_reset,
   input  logic                             i_head_valid,
   input  io_soc_pkg::io_req_t              i_head,
   input  logic                             i_rsp_credit,
   input  logic [io_soc_pkg::DATA_W-1:0]    i_sys_rdata,
   input  logic [io_soc_pkg::DATA_W-1:0]    i_gpio_rdata,
   output logic                             o_pop_ready,
   output io_soc_pkg::periph_req_t          o_sys_req,
   output io_soc_pkg::periph_req_t          o_gpio_req,
   output logic                             o_rsp_valid,
   output io_soc_pkg::io_rsp_t              o_rsp
);

   import io_soc_pkg::*;

   io_region_e        region;
   periph_req_t       base_req;
   logic [DATA_W-1:0] rd_word;
   logic [CRD_W-1:0]  rsp_credits;
   logic              pop;

   assign o_pop_ready = (rsp_credits != '0);
   assign pop         = i_head_valid && o_pop_ready;

   // ********************
   // Address decode
   // ********************
   always_comb begin
      case (i_head.addr[ADDR_W-1 -: 2])
         2'd0:    region = REGION_SYS;
         2'd1:    region = REGION_GPIO;
         default: region = REGION_NONE;
      endcase
   end

   always_comb begin
      base_req.sel     = 1'b0;
      base_req.write   = (i_head.op == OP_WRITE);
      base_req.reg_idx = i_head.addr[2 +: REG_W];
      base_req.wdata   = i_head.wdata;
      base_req.strb    = i_head.strb;
      o_sys_req        = base_req;
      o_sys_req.sel    = pop && (region == REGION_SYS);
      o_gpio_req       = base_req;
      o_gpio_req.sel   = pop && (region == REGION_GPIO);
   end

   // Writes and unmapped accesses answer zero
   always_comb begin
      rd_word = '0;
      if (i_head.op == OP_READ) begin
         case (region)
            REGION_SYS:  rd_word = i_sys_rdata;
            REGION_GPIO: rd_word = i_gpio_rdata;
            default:     rd_word = '0;
         endcase
      end
   end

   // ********************
   // Response channel
   // ********************
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         o_rsp_valid <= 1'b0;
      end else begin
         o_rsp_valid <= pop;
      end
   end

   always_ff @(posedge i_clk) begin
      if (pop) begin
         o_rsp.rdata <= rd_word;
         o_rsp.err   <= (region == REGION_NONE);
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         rsp_credits <= CRD_W'(RSP_CREDITS);
      end else begin
         case ({i_rsp_credit, pop})
            2'b10:   rsp_credits <= rsp_credits + 1'b1;
            2'b01:   rsp_credits <= rsp_credits - 1'b1;
            default: rsp_credits <= rsp_credits;
         endcase
      end
   end

   // Host can only hand back credits for responses it received
   a_credit_return: assert property (@(posedge i_clk) disable iff (i_reset)
      i_rsp_credit |-> (rsp_credits < CRD_W'(RSP_CREDITS)))
      else $error("host returned more credits than responses");

endmodule

// File: rtl/io_req_fifo.sv
module io_req_fifo (
   input  logic                i_clk,
   input  logic                i_reset,
   input  logic                i_req_valid,
   input  io_soc_pkg::io_req_t i_req,
   input  logic                i_pop_ready,
   output logic                o_req_credit,
   output logic                o_head_valid,
   output io_soc_pkg::io_req_t o_head
);

   import io_soc_pkg::*;

   io_req_t          mem [REQ_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   assign push = i_req_valid;
   assign pop  = o_head_valid && i_pop_ready;

   assign o_head_valid = (count != '0);
   assign o_head       = mem[rd_ptr];

   // One credit back per dequeued entry
   assign o_req_credit = pop;

   always_ff @(posedge i_clk) begin
      if (push) begin
         mem[wr_ptr] <= i_req;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Host must never send without a credit in hand
   a_no_push_full: assert property (@(posedge i_clk) disable iff (i_reset)
      i_req_valid |-> (count < CNT_W'(REQ_DEPTH)))
      else $error("request pushed into a full buffer, host credit count broken");

endmodule

// File: rtl/io_soc_pkg.sv
package io_soc_pkg;

   // ********************
   // Widths and depths
   // ********************
   localparam int DATA_W      = 32;
   localparam int ADDR_W      = 8;
   localparam int STRB_W      = 4;
   localparam int GPIO_W      = 8;
   localparam int REG_W       = 4;
   localparam int REQ_DEPTH   = 2;
   localparam int RSP_CREDITS = 2;
   localparam int PTR_W       = $clog2(REQ_DEPTH);
   localparam int CNT_W       = $clog2(REQ_DEPTH + 1);
   localparam int CRD_W       = $clog2(RSP_CREDITS + 1);

   localparam logic [DATA_W-1:0] SOC_ID = 32'h10C0_50C1;

   // ********************
   // Register offsets
   // ********************
   localparam logic [REG_W-1:0] SYS_ID       = 4'd0;
   localparam logic [REG_W-1:0] SYS_SWIRQ    = 4'd1;
   localparam logic [REG_W-1:0] SYS_MTIME    = 4'd2;
   localparam logic [REG_W-1:0] SYS_MTIMECMP = 4'd3;

   localparam logic [REG_W-1:0] GPIO_OUT  = 4'd0;
   localparam logic [REG_W-1:0] GPIO_OE   = 4'd1;
   localparam logic [REG_W-1:0] GPIO_IN   = 4'd2;
   localparam logic [REG_W-1:0] GPIO_EDGE = 4'd3;
   localparam logic [REG_W-1:0] GPIO_IE   = 4'd4;

   typedef enum logic {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } io_op_e;

   // Regions 2 and 3 are both unmapped
   typedef enum logic [1:0] {
      REGION_SYS  = 2'd0,
      REGION_GPIO = 2'd1,
      REGION_NONE = 2'd2
   } io_region_e;

   typedef struct packed {
      io_op_e              op;
      logic [ADDR_W-1:0]   addr;
      logic [DATA_W-1:0]   wdata;
      logic [STRB_W-1:0]   strb;
   } io_req_t;

   typedef struct packed {
      logic [DATA_W-1:0]   rdata;
      logic                err;
   } io_rsp_t;

   typedef struct packed {
      logic                sel;
      logic                write;
      logic [REG_W-1:0]    reg_idx;
      logic [DATA_W-1:0]   wdata;
      logic [STRB_W-1:0]   strb;
   } periph_req_t;

   typedef struct packed {
      logic                timer;
      logic [1:0]          sw;
      logic                gpio;
   } irq_vec_t;

   // Byte strobes expanded to a bit mask
   function automatic logic [DATA_W-1:0] strb_mask(input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] mask;
      for (int i = 0; i < STRB_W; i++) begin
         mask[8*i +: 8] = {8{strb[i]}};
      end
      return mask;
   endfunction

endpackage

// File: rtl/io_soc_top.sv
module io_soc_top (
   input  logic                          i_clk,
   input  logic                          i_reset,
   input  logic                          i_req_valid,
   input  io_soc_pkg::io_req_t           i_req,
   input  logic                          i_rsp_credit,
   input  logic [io_soc_pkg::GPIO_W-1:0] i_gpio,
   output logic                          o_req_credit,
   output logic                          o_rsp_valid,
   output io_soc_pkg::io_rsp_t           o_rsp,
   output io_soc_pkg::irq_vec_t          o_irq,
   output logic [io_soc_pkg::GPIO_W-1:0] o_gpio,
   output logic [io_soc_pkg::GPIO_W-1:0] o_gpio_oe
);

   import io_soc_pkg::*;

   io_req_t           head;
   logic              head_valid;
   logic              pop_ready;
   periph_req_t       sys_req;
   periph_req_t       gpio_req;
   logic [DATA_W-1:0] sys_rdata;
   logic [DATA_W-1:0] gpio_rdata;
   logic              timer_irq;
   logic [1:0]        sw_irq;
   logic              gpio_irq;

   // ********************
   // Request path
   // ********************
   io_req_fifo u_req_fifo (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_req_valid  (i_req_valid),
      .i_req        (i_req),
      .i_pop_ready  (pop_ready),
      .o_req_credit (o_req_credit),
      .o_head_valid (head_valid),
      .o_head       (head)
   );

   io_decoder u_decoder (
      .i_clk        (i_clk),
      .i_reset      (i_reset),
      .i_head_valid (head_valid),
      .i_head       (head),
      .i_rsp_credit (i_rsp_credit),
      .i_sys_rdata  (sys_rdata),
      .i_gpio_rdata (gpio_rdata),
      .o_pop_ready  (pop_ready),
      .o_sys_req    (sys_req),
      .o_gpio_req   (gpio_req),
      .o_rsp_valid  (o_rsp_valid),
      .o_rsp        (o_rsp)
   );

   // ********************
   // Peripherals
   // ********************
   sys_ctrl u_sys_ctrl (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_req       (sys_req),
      .o_rdata     (sys_rdata),
      .o_timer_irq (timer_irq),
      .o_sw_irq    (sw_irq)
   );

   gpio_port u_gpio (
      .i_clk     (i_clk),
      .i_reset   (i_reset),
      .i_req     (gpio_req),
      .i_gpio    (i_gpio),
      .o_rdata   (gpio_rdata),
      .o_gpio    (o_gpio),
      .o_gpio_oe (o_gpio_oe),
      .o_irq     (gpio_irq)
   );

   assign o_irq = '{timer: timer_irq, sw: sw_irq, gpio: gpio_irq};

endmodule

// File: rtl/sys_ctrl.sv
module sys_ctrl (
   input  logic                          i_clk,
   input  logic                          i_reset,
   input  io_soc_pkg::periph_req_t       i_req,
   output logic [io_soc_pkg::DATA_W-1:0] o_rdata,
   output logic                          o_timer_irq,
   output logic [1:0]                    o_sw_irq
);

   import io_soc_pkg::*;

   logic [DATA_W-1:0] mtime;
   logic [DATA_W-1:0] mtimecmp;
   logic [DATA_W-1:0] wmask;
   logic              wr;

   assign wr    = i_req.sel && i_req.write;
   assign wmask = strb_mask(i_req.strb);

   // ********************
   // Machine timer
   // ********************
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         mtime <= '0;
      end else if (wr && (i_req.reg_idx == SYS_MTIME)) begin
         mtime <= (mtime & ~wmask) | (i_req.wdata & wmask);
      end else begin
         mtime <= mtime + 1'b1;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         mtimecmp <= '1;
      end else if (wr && (i_req.reg_idx == SYS_MTIMECMP)) begin
         mtimecmp <= (mtimecmp & ~wmask) | (i_req.wdata & wmask);
      end
   end

   assign o_timer_irq = (mtime >= mtimecmp);

   // Software interrupt bits live in byte 0
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         o_sw_irq <= '0;
      end else if (wr && (i_req.reg_idx == SYS_SWIRQ) && i_req.strb[0]) begin
         o_sw_irq <= i_req.wdata[1:0];
      end
   end

   // ********************
   // Read back
   // ********************
   always_comb begin
      case (i_req.reg_idx)
         SYS_ID:       o_rdata = SOC_ID;
         SYS_SWIRQ:    o_rdata = {{(DATA_W-2){1'b0}}, o_sw_irq};
         SYS_MTIME:    o_rdata = mtime;
         SYS_MTIMECMP: o_rdata = mtimecmp;
         default:      o_rdata = '0;
      endcase
   end

endmodule

// File: test/tb_io_soc_table.svh
`ifndef TB_IO_SOC_TABLE_SVH
`define TB_IO_SOC_TABLE_SVH

// Each row holds op, addr, wdata, strb, the pins driven on i_gpio, the expected {rdata, err},
// the expected irq {timer, sw[1:0], gpio}, the expected o_gpio and the expected o_gpio_oe
localparam int N_ROWS = 27;

row_t rows [N_ROWS] = '{
   // ********************
   // ID and unmapped regions
   // ********************
   '{OP_READ,  8'h00, 32'h00000000, 4'h0, 8'h00, {SOC_ID, 1'b0}, 4'b0000, 8'h00, 8'h00},
   '{OP_WRITE, 8'h80, 32'hFFFFFFFF, 4'hF, 8'h00, {32'h0, 1'b1}, 4'b0000, 8'h00, 8'h00},
   '{OP_READ,  8'h40, 32'h00000000, 4'h0, 8'h00, {32'h0, 1'b0}, 4'b0000, 8'h00, 8'h00},
   '{OP_READ,  8'hC4, 32'h00000000, 4'h0, 8'h00, {32'h0, 1'b1}, 4'b0000, 8'h00, 8'h00},
   // ********************
   // GPIO output and enable
   // ********************
   '{OP_WRITE, 8'h40, 32'h000000A5, 4'h1, 8'h00, {32'h0, 1'b0}, 4'b0000, 8'hA5, 8'h00},
   '{OP_WRITE, 8'h40, 32'h00005A00, 4'h2, 8'h00, {32'h0, 1'b0}, 4'b0000, 8'hA5, 8'h00},
   '{OP_READ,  8'h40, 32'h00000000, 4'h0, 8'h00, {32'hA5, 1'b0}, 4'b0000, 8'hA5, 8'h00},
   '{OP_WRITE, 8'h44, 32'h000000F0, 4'h1, 8'h00, {32'h0, 1'b0}, 4'b0000, 8'hA5, 8'hF0},
   '{OP_WRITE, 8'h44, 32'hFFFFFFFF, 4'hE, 8'h00, {32'h0, 1'b0}, 4'b0000, 8'hA5, 8'hF0},
   '{OP_READ,  8'h44, 32'h00000000, 4'h0, 8'h00, {32'hF0, 1'b0}, 4'b0000, 8'hA5, 8'hF0},
   // ********************
   // Software and timer irq
   // ********************
   '{OP_WRITE, 8'h04, 32'h00000002, 4'h1, 8'h00, {32'h0, 1'b0}, 4'b0100, 8'hA5, 8'hF0},
   '{OP_READ,  8'h04, 32'h00000000, 4'h0, 8'h00, {32'h2, 1'b0}, 4'b0100, 8'hA5, 8'hF0},
   '{OP_WRITE, 8'h0C, 32'h00000000, 4'hF, 8'h00, {32'h0, 1'b0}, 4'b1100, 8'hA5, 8'hF0},
   '{OP_READ,  8'h0C, 32'h00000000, 4'h0, 8'h00, {32'h0, 1'b0}, 4'b1100, 8'hA5, 8'hF0},
   '{OP_WRITE, 8'h0C, 32'hFFFFFFFF, 4'hF, 8'h00, {32'h0, 1'b0}, 4'b0100, 8'hA5, 8'hF0},
   '{OP_READ,  8'h0C, 32'h00000000, 4'h0, 8'h00, {32'hFFFFFFFF, 1'b0}, 4'b0100, 8'hA5, 8'hF0},
   '{OP_WRITE, 8'h04, 32'h00000000, 4'h1, 8'h00, {32'h0, 1'b0}, 4'b0000, 8'hA5, 8'hF0},
   // ********************
   // Edge capture with pin 0 undriven and pins 4 and 5 driven
   // ********************
   '{OP_WRITE, 8'h50, 32'h000000FF, 4'h1, 8'h00, {32'h0, 1'b0}, 4'b0000, 8'hA5, 8'hF0},
   '{OP_READ,  8'h48, 32'h00000000, 4'h0, 8'h11, {32'h11, 1'b0}, 4'b0001, 8'hA5, 8'hF0},
   '{OP_READ,  8'h4C, 32'h00000000, 4'h0, 8'h11, {32'h01, 1'b0}, 4'b0001, 8'hA5, 8'hF0},
   '{OP_WRITE, 8'h4C, 32'h00000001, 4'h1, 8'h11, {32'h0, 1'b0}, 4'b0000, 8'hA5, 8'hF0},
   '{OP_READ,  8'h4C, 32'h00000000, 4'h0, 8'h11, {32'h0, 1'b0}, 4'b0000, 8'hA5, 8'hF0},
   '{OP_READ,  8'h48, 32'h00000000, 4'h0, 8'h31, {32'h31, 1'b0}, 4'b0000, 8'hA5, 8'hF0},
   '{OP_READ,  8'h4C, 32'h00000000, 4'h0, 8'h31, {32'h0, 1'b0}, 4'b0000, 8'hA5, 8'hF0},
   '{OP_WRITE, 8'h40, 32'h0000003C, 4'hF, 8'h31, {32'h0, 1'b0}, 4'b0000, 8'h3C, 8'hF0},
   '{OP_READ,  8'h40, 32'h00000000, 4'h0, 8'h31, {32'h3C, 1'b0}, 4'b0000, 8'h3C, 8'hF0},
   '{OP_READ,  8'h00, 32'h00000000, 4'h0, 8'h31, {SOC_ID, 1'b0}, 4'b0000, 8'h3C, 8'hF0}
};

`endif

// File: test/tb_io_soc.sv
module tb_io_soc;

   import io_soc_pkg::*;

   typedef struct packed {
      io_op_e            op;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] strb;
      logic [GPIO_W-1:0] pins;
      io_rsp_t           rsp;
      irq_vec_t          irq;
      logic [GPIO_W-1:0] gpio;
      logic [GPIO_W-1:0] oe;
   } row_t;

   `include "tb_io_soc_table.svh"

   localparam int CYCLE_LIMIT = 30 * N_ROWS + 100;
   // Wait after a pin change covers both synchronizer flops
   localparam int PIN_SETTLE  = 4;

   logic              i_clk;
   logic              i_reset;
   logic              i_req_valid;
   io_req_t           i_req;
   logic              i_rsp_credit;
   logic [GPIO_W-1:0] i_gpio;
   logic              o_req_credit;
   logic              o_rsp_valid;
   io_rsp_t           o_rsp;
   irq_vec_t          o_irq;
   logic [GPIO_W-1:0] o_gpio;
   logic [GPIO_W-1:0] o_gpio_oe;

   io_soc_top DUT (.*);

   initial begin
      i_clk = 1'b0;
      forever #20 i_clk = ~i_clk;
   end

   // ********************
   // Failure reporting
   // ********************
   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic report_mismatch(input string msg);
      stop_run($sformatf("mismatch at time %0t: %s", $time, msg));
   endtask

   task automatic check_rsp(input io_rsp_t got, input io_rsp_t exp, input int row);
      if (got !== exp) begin
         report_mismatch($sformatf("row %0d rdata %h err %b, expected rdata %h err %b",
            row, got.rdata, got.err, exp.rdata, exp.err));
      end
   endtask

   task automatic check_irq(input irq_vec_t got, input irq_vec_t exp, input int row);
      if (got !== exp) begin
         report_mismatch($sformatf("row %0d irq %b, expected %b", row, got, exp));
      end
   endtask

   task automatic check_pins(input logic [GPIO_W-1:0] got, input logic [GPIO_W-1:0] exp,
                             input string what, input int row);
      if (got !== exp) begin
         report_mismatch($sformatf("row %0d %s %h, expected %h", row, what, got, exp));
      end
   endtask

   // ********************
   // Credit-tracking host
   // ********************
   initial begin : host
      int                cycle;
      int                credits;
      int                row;
      int                idx;
      int                rsp_count;
      int                wait_cnt;
      int                delay;
      int                seed;
      int                exp_q [$];
      int                due_q [$];
      logic [GPIO_W-1:0] pins_now;

      cycle        = 0;
      credits      = REQ_DEPTH;
      row          = 0;
      rsp_count    = 0;
      wait_cnt     = 0;
      seed         = 32316;
      pins_now     = '0;
      i_reset      = 1'b1;
      i_req_valid  = 1'b0;
      i_req        = '0;
      i_rsp_credit = 1'b0;
      i_gpio       = '0;
      repeat (8) @(posedge i_clk);
      i_reset <= 1'b0;

      while (rsp_count < N_ROWS && cycle < CYCLE_LIMIT) begin
         @(negedge i_clk);
         if (o_req_credit) begin
            credits++;
         end
         if (credits > REQ_DEPTH) begin
            stop_run("request credits returned exceed the requests sent");
         end
         if (o_rsp_valid) begin
            if (exp_q.size() == 0) begin
               stop_run("response arrived with no request outstanding");
            end
            idx = exp_q.pop_front();
            check_rsp(o_rsp, rows[idx].rsp, idx);
            check_irq(o_irq, rows[idx].irq, idx);
            check_pins(o_gpio, rows[idx].gpio, "o_gpio", idx);
            check_pins(o_gpio_oe, rows[idx].oe, "o_gpio_oe", idx);
            // Random hold-off creates back-pressure on the response side
            delay = $unsigned($random(seed)) % 4;
            due_q.push_back(cycle + delay);
            rsp_count++;
         end

         @(posedge i_clk);
         i_req_valid  <= 1'b0;
         i_rsp_credit <= 1'b0;
         if (due_q.size() != 0 && due_q[0] <= cycle) begin
            i_rsp_credit <= 1'b1;
            void'(due_q.pop_front());
         end
         if (wait_cnt != 0) begin
            wait_cnt--;
         end else if (row < N_ROWS && credits != 0) begin
            if (rows[row].pins != pins_now) begin
               // Pins change only once every earlier response is back
               if (exp_q.size() == 0) begin
                  i_gpio   <= rows[row].pins;
                  pins_now = rows[row].pins;
                  wait_cnt = PIN_SETTLE;
               end
            end else begin
               i_req_valid <= 1'b1;
               i_req       <= '{op: rows[row].op, addr: rows[row].addr,
                                wdata: rows[row].wdata, strb: rows[row].strb};
               exp_q.push_back(row);
               credits--;
               row++;
            end
         end
         cycle++;
      end

      if (rsp_count == N_ROWS && exp_q.size() == 0) begin
         $display("TEST PASSED");
         $finish;
      end else begin
         $display("run timed out after %0d cycles with %0d of %0d responses received",
            cycle, rsp_count, N_ROWS);
         $display("TEST FAILED");
         $fatal(1, "timeout");
      end
   end

endmodule
